// File: fp_pkg.sv
`default_nettype none

package fp_pkg;

    // Register file geometry
    localparam int unsigned FLEN         = 64;
    localparam int unsigned FREG_NUM     = 32;
    localparam int unsigned FREG_IDX_LEN = $clog2(FREG_NUM);

    // Commit buffer geometry
    // Depth must stay a power of two so the pointers wrap on their own
    localparam int unsigned FIFO_DEPTH   = 4;
    localparam int unsigned FIFO_PTR_LEN = $clog2(FIFO_DEPTH);

    // IEEE 754 double layout
    localparam int unsigned DBL_EXP_LEN  = 11;
    localparam int unsigned DBL_MANT_LEN = 52;

    // Single precision word and its box
    localparam int unsigned SGL_LEN      = 32;

    // Upper half of a properly NaN-boxed single
    localparam logic [SGL_LEN-1:0] BOX_ONES    = '1;

    // Canonical quiet NaN for single precision
    // Sign clear, exponent all ones, only the top mantissa bit set
    localparam logic [SGL_LEN-1:0] CANON_NAN_S = 32'h7fc0_0000;

    // Register word seen as a double
    typedef struct packed {
        logic                    sign;
        logic [DBL_EXP_LEN-1:0]  exponent;
        logic [DBL_MANT_LEN-1:0] mantissa;
    } fp_double_t;

    // Register word seen as a boxed single
    // The box must be all ones for the single to be valid
    typedef struct packed {
        logic [SGL_LEN-1:0] box;
        logic [SGL_LEN-1:0] single_val;
    } fp_boxed_t;

    // One 64-bit register word, decoded by the format of the instruction
    typedef union packed {
        fp_double_t dbl;
        fp_boxed_t  boxed;
    } fp_word_u;

endpackage

`default_nettype wire

// File: fp_rf.sv
`timescale 1ns/1ps
`default_nettype none

module fp_rf (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    // Single write port, driven by the arbiter
    input  logic                            we_i,
    input  logic [fp_pkg::FREG_IDX_LEN-1:0] widx_i,
    input  logic [fp_pkg::FLEN-1:0]         wdata_i,

    // Read ports 1 and 2 serve issue, port 3 serves debug
    input  logic [fp_pkg::FREG_IDX_LEN-1:0] ridx1_i,
    input  logic [fp_pkg::FREG_IDX_LEN-1:0] ridx2_i,
    input  logic [fp_pkg::FREG_IDX_LEN-1:0] ridx3_i,
    output logic [fp_pkg::FLEN-1:0]         rdata1_o,
    output logic [fp_pkg::FLEN-1:0]         rdata2_o,
    output logic [fp_pkg::FLEN-1:0]         rdata3_o
);

    import fp_pkg::*;

    // Register storage
    logic [FLEN-1:0] regs_q [FREG_NUM];

    // Synchronous write
    // All registers come out of reset as +0.0
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < FREG_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i) begin
            regs_q[widx_i] <= wdata_i;
        end
    end

    // Combinational reads
    // A write is seen on the reads right after its edge, no bypass
    assign rdata1_o = regs_q[ridx1_i];
    assign rdata2_o = regs_q[ridx2_i];
    assign rdata3_o = regs_q[ridx3_i];

endmodule

`default_nettype wire

// File: fp_wr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module fp_wr_arbiter (
    // Commit side requester
    input  logic                            cb_req_i,
    input  logic [fp_pkg::FREG_IDX_LEN-1:0] cb_idx_i,
    input  logic [fp_pkg::FLEN-1:0]         cb_data_i,
    output logic                            cb_gnt_o,

    // Debug side requester
    input  logic                            wb_req_i,
    input  logic [fp_pkg::FREG_IDX_LEN-1:0] wb_idx_i,
    input  logic [fp_pkg::FLEN-1:0]         wb_data_i,
    output logic                            wb_gnt_o,

    // Write port of the register file
    output logic                            we_o,
    output logic [fp_pkg::FREG_IDX_LEN-1:0] widx_o,
    output logic [fp_pkg::FLEN-1:0]         wdata_o
);

    // Fixed priority
    // Commit always wins, debug only gets the idle cycles
    assign cb_gnt_o = cb_req_i;
    assign wb_gnt_o = wb_req_i & ~cb_req_i;

    // Any granted request writes this cycle
    assign we_o = cb_gnt_o | wb_gnt_o;

    // Steer index and data from the winner
    always_comb begin
        if (cb_gnt_o) begin
            widx_o  = cb_idx_i;
            wdata_o = cb_data_i;
        end else begin
            // Debug values pass even when idle, we_o masks them
            widx_o  = wb_idx_i;
            wdata_o = wb_data_i;
        end
    end

endmodule

`default_nettype wire

// File: fp_commit_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module fp_commit_buffer (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    // Results from the commit logic
    input  logic                            push_valid_i,
    output logic                            push_ready_o,
    input  logic [fp_pkg::FREG_IDX_LEN-1:0] push_idx_i,
    input  logic [fp_pkg::FLEN-1:0]         push_value_i,
    input  logic                            push_single_i,

    // Write request toward the arbiter
    output logic                            req_o,
    output logic [fp_pkg::FREG_IDX_LEN-1:0] idx_o,
    output logic [fp_pkg::FLEN-1:0]         data_o,
    input  logic                            gnt_i
);

    import fp_pkg::*;

    // Entry storage
    logic [FREG_IDX_LEN-1:0] idx_mem  [FIFO_DEPTH];
    fp_word_u                data_mem [FIFO_DEPTH];

    // Pointers and occupancy
    logic [FIFO_PTR_LEN-1:0] wr_ptr_q;
    logic [FIFO_PTR_LEN-1:0] rd_ptr_q;
    logic [FIFO_PTR_LEN:0]   count_q;

    logic     push;
    logic     pop;
    fp_word_u push_word;

    // Handshakes
    assign push_ready_o = (count_q != (FIFO_PTR_LEN+1)'(FIFO_DEPTH));
    assign push         = push_valid_i & push_ready_o;
    assign req_o        = (count_q != '0);
    assign pop          = req_o & gnt_i;

    // NaN-box single results on the way in
    always_comb begin
        push_word = push_value_i;
        if (push_single_i) begin
            push_word.boxed.box = BOX_ONES;
        end
    end

    // Payload storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            idx_mem[wr_ptr_q]  <= push_idx_i;
            data_mem[wr_ptr_q] <= push_word;
        end
    end

    // Pointer and count update
    // Push and pop together leave the count unchanged
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Head entry drives the request
    assign idx_o  = idx_mem[rd_ptr_q];
    assign data_o = data_mem[rd_ptr_q];

endmodule

`default_nettype wire

// File: wb_fp_rf_port.sv
`timescale 1ns/1ps
`default_nettype none

module wb_fp_rf_port (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    // Wishbone classic slave
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    input  logic                            wb_we_i,
    input  logic [fp_pkg::FREG_IDX_LEN-1:0] wb_adr_i,
    input  logic [fp_pkg::FLEN-1:0]         wb_dat_i,
    output logic [fp_pkg::FLEN-1:0]         wb_dat_o,
    output logic                            wb_ack_o,

    // Write request toward the arbiter
    output logic                            req_o,
    output logic [fp_pkg::FREG_IDX_LEN-1:0] idx_o,
    output logic [fp_pkg::FLEN-1:0]         data_o,
    input  logic                            gnt_i,

    // Debug read port of the register file
    output logic [fp_pkg::FREG_IDX_LEN-1:0] ridx_o,
    input  logic [fp_pkg::FLEN-1:0]         rdata_i
);

    import fp_pkg::*;

    logic            ack_q;
    logic            wr_pend_q;
    logic [FLEN-1:0] dat_q;
    logic            new_cycle;

    // New access only when nothing is in flight
    // The ack flag keeps the ack cycle from starting a second access
    assign new_cycle = wb_cyc_i & wb_stb_i & ~ack_q & ~wr_pend_q;

    // Master holds address and data until ack
    assign ridx_o = wb_adr_i;
    assign idx_o  = wb_adr_i;
    assign data_o = wb_dat_i;
    assign req_o  = wr_pend_q;

    // Control FSM
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q     <= 1'b0;
            wr_pend_q <= 1'b0;
        end else begin
            // Ack is a one-cycle pulse
            ack_q <= 1'b0;
            if (new_cycle && !wb_we_i) begin
                ack_q <= 1'b1;
            end else if (new_cycle && wb_we_i) begin
                wr_pend_q <= 1'b1;
            end else if (wr_pend_q && !wb_cyc_i) begin
                // Master gave up, drop the write
                wr_pend_q <= 1'b0;
            end else if (wr_pend_q && gnt_i) begin
                // Write lands at this edge
                wr_pend_q <= 1'b0;
                ack_q     <= 1'b1;
            end
        end
    end

    // Read data register
    always_ff @(posedge clk_i) begin
        if (new_cycle && !wb_we_i) begin
            dat_q <= rdata_i;
        end
    end

    assign wb_dat_o = dat_q;
    assign wb_ack_o = ack_q;

endmodule

`default_nettype wire

// File: fp_operand_unbox.sv
`timescale 1ns/1ps
`default_nettype none

module fp_operand_unbox (
    input  logic [fp_pkg::FLEN-1:0] value_i,
    input  logic                    single_i,
    output logic [fp_pkg::FLEN-1:0] value_o
);

    import fp_pkg::*;

    fp_word_u in_word;
    logic     box_ok;

    // Raw register word decoded by operand format
    assign in_word = value_i;
    assign box_ok  = (in_word.boxed.box == BOX_ONES);

    // Doubles and well boxed singles pass untouched
    // A single without a full box reads as the boxed canonical NaN
    always_comb begin
        if (!single_i || box_ok) begin
            value_o = in_word;
        end else begin
            value_o = {BOX_ONES, CANON_NAN_S};
        end
    end

endmodule

`default_nettype wire

// File: fp_rf_top.sv
`timescale 1ns/1ps
`default_nettype none

module fp_rf_top (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    // Commit input
    input  logic                            cm_valid_i,
    output logic                            cm_ready_o,
    input  logic [fp_pkg::FREG_IDX_LEN-1:0] cm_idx_i,
    input  logic [fp_pkg::FLEN-1:0]         cm_value_i,
    input  logic                            cm_single_i,

    // Debug Wishbone slave
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    input  logic                            wb_we_i,
    input  logic [fp_pkg::FREG_IDX_LEN-1:0] wb_adr_i,
    input  logic [fp_pkg::FLEN-1:0]         wb_dat_i,
    output logic [fp_pkg::FLEN-1:0]         wb_dat_o,
    output logic                            wb_ack_o,

    // Issue operands
    input  logic [fp_pkg::FREG_IDX_LEN-1:0] iss_rs1_idx_i,
    input  logic [fp_pkg::FREG_IDX_LEN-1:0] iss_rs2_idx_i,
    input  logic                            iss_rs1_single_i,
    input  logic                            iss_rs2_single_i,
    output logic [fp_pkg::FLEN-1:0]         iss_rs1_value_o,
    output logic [fp_pkg::FLEN-1:0]         iss_rs2_value_o
);

    import fp_pkg::*;

    // Commit side request
    logic                    cb_req;
    logic                    cb_gnt;
    logic [FREG_IDX_LEN-1:0] cb_idx;
    logic [FLEN-1:0]         cb_data;

    // Debug side request
    logic                    wb_req;
    logic                    wb_gnt;
    logic [FREG_IDX_LEN-1:0] wb_idx;
    logic [FLEN-1:0]         wb_data;

    // Register file write port
    logic                    we;
    logic [FREG_IDX_LEN-1:0] widx;
    logic [FLEN-1:0]         wdata;

    // Read data before unboxing, and debug read port
    logic [FLEN-1:0]         rs1_raw;
    logic [FLEN-1:0]         rs2_raw;
    logic [FREG_IDX_LEN-1:0] dbg_ridx;
    logic [FLEN-1:0]         dbg_rdata;

    fp_commit_buffer u_commit_buffer (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .push_valid_i  (cm_valid_i),
        .push_ready_o  (cm_ready_o),
        .push_idx_i    (cm_idx_i),
        .push_value_i  (cm_value_i),
        .push_single_i (cm_single_i),
        .req_o         (cb_req),
        .idx_o         (cb_idx),
        .data_o        (cb_data),
        .gnt_i         (cb_gnt)
    );

    wb_fp_rf_port u_wb_port (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .req_o    (wb_req),
        .idx_o    (wb_idx),
        .data_o   (wb_data),
        .gnt_i    (wb_gnt),
        .ridx_o   (dbg_ridx),
        .rdata_i  (dbg_rdata)
    );

    // Commit has priority on the single write port
    fp_wr_arbiter u_arbiter (
        .cb_req_i  (cb_req),
        .cb_idx_i  (cb_idx),
        .cb_data_i (cb_data),
        .cb_gnt_o  (cb_gnt),
        .wb_req_i  (wb_req),
        .wb_idx_i  (wb_idx),
        .wb_data_i (wb_data),
        .wb_gnt_o  (wb_gnt),
        .we_o      (we),
        .widx_o    (widx),
        .wdata_o   (wdata)
    );

    fp_rf u_rf (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .we_i     (we),
        .widx_i   (widx),
        .wdata_i  (wdata),
        .ridx1_i  (iss_rs1_idx_i),
        .ridx2_i  (iss_rs2_idx_i),
        .ridx3_i  (dbg_ridx),
        .rdata1_o (rs1_raw),
        .rdata2_o (rs2_raw),
        .rdata3_o (dbg_rdata)
    );

    // One unboxer per issue operand
    fp_operand_unbox unbox_rs1 (
        .value_i  (rs1_raw),
        .single_i (iss_rs1_single_i),
        .value_o  (iss_rs1_value_o)
    );

    fp_operand_unbox unbox_rs2 (
        .value_i  (rs2_raw),
        .single_i (iss_rs2_single_i),
        .value_o  (iss_rs2_value_o)
    );

endmodule

`default_nettype wire

// File: tb_fp_rf_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fp_rf_top;

    import fp_pkg::*;

    localparam int TIMEOUT = 50;
    // Boxed canonical single NaN as defined by the F extension
    localparam logic [63:0] NAN_WORD = 64'hffff_ffff_7fc0_0000;

    logic clk;
    logic rst_n;
    logic cm_valid;
    logic cm_ready;
    logic [FREG_IDX_LEN-1:0] cm_idx;
    logic [FLEN-1:0] cm_value;
    logic cm_single;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [FREG_IDX_LEN-1:0] wb_adr;
    logic [FLEN-1:0] wb_dat;
    logic [FLEN-1:0] wb_rdat;
    logic wb_ack;
    logic [FREG_IDX_LEN-1:0] iss_rs1_idx;
    logic [FREG_IDX_LEN-1:0] iss_rs2_idx;
    logic iss_rs1_single;
    logic iss_rs2_single;
    logic [FLEN-1:0] iss_rs1_value;
    logic [FLEN-1:0] iss_rs2_value;

    // Mirror of the register file
    logic [FLEN-1:0] ref_regs [FREG_NUM];

    // Bookkeeping shared by stimulus and compare process
    integer seed = 12873;
    int err_cnt = 0;
    int chk_cnt = 0;
    int stall_cnt = 0;
    int chk_kind;
    logic [FLEN-1:0] wb_got;
    logic [FLEN-1:0] wb_exp;
    logic [FREG_IDX_LEN-1:0] wb_chk_idx;
    event check_ev;

    fp_rf_top dut0 (
        .clk_i(clk), .rst_n_i(rst_n),
        .cm_valid_i(cm_valid), .cm_ready_o(cm_ready), .cm_idx_i(cm_idx),
        .cm_value_i(cm_value), .cm_single_i(cm_single),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
        .wb_dat_i(wb_dat), .wb_dat_o(wb_rdat), .wb_ack_o(wb_ack),
        .iss_rs1_idx_i(iss_rs1_idx), .iss_rs2_idx_i(iss_rs2_idx),
        .iss_rs1_single_i(iss_rs1_single), .iss_rs2_single_i(iss_rs2_single),
        .iss_rs1_value_o(iss_rs1_value), .iss_rs2_value_o(iss_rs2_value)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Expected issue value under the NaN-boxing rule for singles
    function automatic logic [FLEN-1:0] ref_read(input logic [FREG_IDX_LEN-1:0] idx,
                                                 input logic single);
        fp_word_u w;
        w = ref_regs[idx];
        if (single && w.boxed.box != 32'hffff_ffff) begin
            w = NAN_WORD;
        end
        return w;
    endfunction

    // Commit stores singles with the upper half forced to ones
    function automatic logic [FLEN-1:0] ref_commit(input logic [FLEN-1:0] value,
                                                   input logic single);
        return single ? {32'hffff_ffff, value[31:0]} : value;
    endfunction

    // Compare process woken by the stimulus once the inputs have settled
    initial begin : compare_proc
        logic [FLEN-1:0] exp1;
        logic [FLEN-1:0] exp2;
        forever begin
            @(check_ev);
            if (chk_kind == 0) begin
                exp1 = ref_read(iss_rs1_idx, iss_rs1_single);
                exp2 = ref_read(iss_rs2_idx, iss_rs2_single);
                chk_cnt += 2;
                assert (iss_rs1_value === exp1) else begin
                    $display("FAILED iss_rs1_value_o reg %0d single %0b: got %h expected %h",
                             iss_rs1_idx, iss_rs1_single, iss_rs1_value, exp1);
                    err_cnt++;
                end
                assert (iss_rs2_value === exp2) else begin
                    $display("FAILED iss_rs2_value_o reg %0d single %0b: got %h expected %h",
                             iss_rs2_idx, iss_rs2_single, iss_rs2_value, exp2);
                    err_cnt++;
                end
            end else begin
                chk_cnt++;
                assert (wb_got === wb_exp) else begin
                    $display("FAILED wb_dat_o reg %0d: got %h expected %h",
                             wb_chk_idx, wb_got, wb_exp);
                    err_cnt++;
                end
            end
        end
    end

    task automatic issue_check(input logic [FREG_IDX_LEN-1:0] a, input logic sa,
                               input logic [FREG_IDX_LEN-1:0] b, input logic sb);
        @(negedge clk);
        iss_rs1_idx = a;
        iss_rs1_single = sa;
        iss_rs2_idx = b;
        iss_rs2_single = sb;
        #2;
        chk_kind = 0;
        ->check_ev;
        #1;
    endtask

    task automatic push_commit(input logic [FREG_IDX_LEN-1:0] idx,
                               input logic [FLEN-1:0] value, input logic single);
        int waited;
        waited = 0;
        @(negedge clk);
        cm_valid = 1'b1;
        cm_idx = idx;
        cm_value = value;
        cm_single = single;
        #1;
        while (!cm_ready && waited < TIMEOUT) begin
            stall_cnt++;
            @(negedge clk);
            #1;
            waited++;
        end
        assert (cm_ready) else begin
            $display("Timeout: commit buffer never became ready for reg %0d", idx);
            err_cnt++;
        end
        if (cm_ready) begin
            // Push lands at this edge
            @(posedge clk);
            ref_regs[idx] = ref_commit(value, single);
        end else begin
            cm_valid = 1'b0;
        end
    endtask

    // Two idle cycles after ready let the last entry land
    task automatic drain_commit();
        int waited;
        waited = 0;
        @(negedge clk);
        cm_valid = 1'b0;
        while (!cm_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (cm_ready) else begin
            $display("Timeout: commit buffer stayed full while draining");
            err_cnt++;
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic wb_access(input logic we, input logic [FREG_IDX_LEN-1:0] adr,
                             input logic [FLEN-1:0] wdat, output logic [FLEN-1:0] rdat,
                             output logic acked);
        int waited;
        waited = 0;
        acked = 1'b0;
        rdat = '0;
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat = wdat;
        while (!acked && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
            acked = wb_ack;
        end
        if (acked) begin
            rdat = wb_rdat;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        assert (acked) else begin
            $display("Timeout: no Wishbone ack for access to reg %0d", adr);
            err_cnt++;
        end
    endtask

    task automatic wb_write(input logic [FREG_IDX_LEN-1:0] adr, input logic [FLEN-1:0] dat);
        logic [FLEN-1:0] rd;
        logic ok;
        wb_access(1'b1, adr, dat, rd, ok);
        if (ok) begin
            ref_regs[adr] = dat;
        end
    endtask

    task automatic wb_read(input logic [FREG_IDX_LEN-1:0] adr);
        logic [FLEN-1:0] rd;
        logic ok;
        wb_access(1'b0, adr, '0, rd, ok);
        if (ok) begin
            wb_got = rd;
            wb_exp = ref_regs[adr];
            wb_chk_idx = adr;
            chk_kind = 1;
            ->check_ev;
            #1;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    initial begin : main_seq
        int base;
        rst_n = 1'b0;
        cm_valid = 1'b0;
        cm_idx = '0;
        cm_value = '0;
        cm_single = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat = '0;
        iss_rs1_idx = '0;
        iss_rs2_idx = '0;
        iss_rs1_single = 1'b0;
        iss_rs2_single = 1'b0;
        for (int i = 0; i < FREG_NUM; i++) begin
            ref_regs[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;

        // Reset state through issue and debug reads
        base = err_cnt;
        assert (wb_ack === 1'b0) else begin
            $display("FAILED wb_ack_o after reset: got %h expected %h", wb_ack, 1'b0);
            err_cnt++;
        end
        assert (cm_ready === 1'b1) else begin
            $display("FAILED cm_ready_o after reset: got %h expected %h", cm_ready, 1'b1);
            err_cnt++;
        end
        for (int i = 0; i < FREG_NUM; i++) begin
            issue_check(FREG_IDX_LEN'(i), 1'b0, FREG_IDX_LEN'(31 - i), 1'b0);
            wb_read(FREG_IDX_LEN'(i));
        end
        report_test("reset_state", base);

        // Random doubles to random registers
        base = err_cnt;
        for (int k = 0; k < 12; k++) begin
            push_commit(FREG_IDX_LEN'($random(seed)), {$random(seed), $random(seed)}, 1'b0);
        end
        drain_commit();
        for (int i = 0; i < FREG_NUM; i++) begin
            issue_check(FREG_IDX_LEN'(i), 1'b0, FREG_IDX_LEN'(31 - i), 1'b0);
        end
        report_test("commit_doubles", base);

        // Singles come back boxed, read either way
        base = err_cnt;
        for (int i = 8; i < 14; i++) begin
            push_commit(FREG_IDX_LEN'(i), {$random(seed), $random(seed)}, 1'b1);
        end
        drain_commit();
        for (int i = 8; i < 14; i++) begin
            issue_check(FREG_IDX_LEN'(i), 1'b1, FREG_IDX_LEN'(i), 1'b0);
        end
        report_test("commit_singles", base);

        // Upper half not all ones, so a single read gives the NaN
        base = err_cnt;
        wb_write(5'd5, 64'h0123_4567_89ab_cdef);
        issue_check(5'd5, 1'b1, 5'd5, 1'b0);
        wb_read(5'd5);
        report_test("debug_unboxed", base);

        // Commit burst while debug waits for the write port
        base = err_cnt;
        stall_cnt = 0;
        fork
            begin
                @(negedge clk);
                wb_write(5'd20, {$random(seed), $random(seed)});
            end
            begin
                for (int k = 0; k < 4; k++) begin
                    push_commit(FREG_IDX_LEN'(k), {$random(seed), $random(seed)}, k[0]);
                end
                drain_commit();
            end
        join
        assert (stall_cnt == 0) else begin
            $display("Commit buffer dropped ready %0d times in a four-push burst", stall_cnt);
            err_cnt++;
        end
        for (int i = 0; i < FREG_NUM; i++) begin
            issue_check(FREG_IDX_LEN'(i), 1'b0, FREG_IDX_LEN'(i), 1'b1);
        end
        wb_read(5'd20);
        report_test("contention", base);

        $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
fp_pkg.sv
fp_rf.sv
fp_wr_arbiter.sv
fp_commit_buffer.sv
wb_fp_rf_port.sv
fp_operand_unbox.sv
fp_rf_top.sv
tb_fp_rf_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the FP register file testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_fp_rf_top -f list.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi

exit 0
